/* icache_top.f */
+incdir+common
common/icache_pkg.sv
common/axi_rd_pkg.sv
icache_way/icache_way.sv
source/icache_hit_lru.sv
source/icache_ctrl.sv
source/icache_top.sv
tb/tb_icache_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_icache_top \
    -f icache_top.f -o sim_icache \
    && ./obj_dir/sim_icache > sim.log 2>&1 \
    || { echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

/* tb/tb_icache_top.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module tb_icache_top
    import icache_pkg::*;
    import axi_rd_pkg::*;
;

    localparam int TIMEOUT    = 200;
    localparam int NUM_STIM   = 26;
    localparam int LINE_WORDS = `ICACHE_LINE_WORDS;

    typedef struct packed {
        addr_t addr;
        logic  stream;
    } stim_t;

    typedef struct packed {
        int idx;
        int acc_cycle;
    } pend_t;

    // stream set means the next request follows with inst_req held high
    stim_t stim_tbl [NUM_STIM] = '{
        '{32'h0000_10a4, 1'b0}, '{32'h0000_10a0, 1'b0}, '{32'h0000_10bc, 1'b1},
        '{32'h0000_10a8, 1'b1}, '{32'h0000_10b0, 1'b1}, '{32'h0000_10ac, 1'b0},
        // same index, three more tags
        '{32'h0000_20a0, 1'b0}, '{32'h0000_30b4, 1'b1}, '{32'h0000_40a8, 1'b1},
        '{32'h0000_10a0, 1'b1}, '{32'h0000_20a4, 1'b1}, '{32'h0000_30a8, 1'b1},
        '{32'h0000_40ac, 1'b0},
        // touch tags 1 and 3, then evict
        '{32'h0000_10b8, 1'b1}, '{32'h0000_30b8, 1'b0}, '{32'h0000_50a0, 1'b0},
        '{32'h0000_20a0, 1'b0}, '{32'h0000_10a4, 1'b1}, '{32'h0000_30a4, 1'b1},
        '{32'h0000_50a4, 1'b0},
        // first and last set
        '{32'h0001_2fe0, 1'b0}, '{32'h0001_2ffc, 1'b0}, '{32'h0000_0000, 1'b0},
        '{32'hffff_f01c, 1'b1}, '{32'h0000_0004, 1'b1}, '{32'hffff_f000, 1'b0}
    };
    logic exp_miss [NUM_STIM];

    logic    clk = 1'b0;
    logic    rst;
    logic    inst_req;
    addr_t   inst_addr;
    logic    inst_addr_ok;
    logic    inst_data_ok;
    word_t   inst_rdata;
    axi_ar_t ar;
    logic    arready = 1'b0;
    axi_r_t  r = '0;
    logic    rready;

    tag_t        model_tags [`ICACHE_SETS][`ICACHE_WAYS];
    int          model_cnt [`ICACHE_SETS];
    logic [31:0] rng = 32'h6f31c46e;
    int          errors;
    int          checks;
    int          cycle;
    int          cur_idx;
    int          ar_count;
    int          last_acc;
    pend_t       pend_q [$];
    pend_t       done_req;
    bit          ar_fire_q;
    bit          r_fire_q;
    addr_t       ar_addr_q;
    int          mem_phase;
    int          mem_cnt;
    int          beat_idx;
    addr_t       burst_addr;
    bit          ok;
    bit          aborted;

    icache_top i_icache_top (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .ar           (ar),
        .arready      (arready),
        .r            (r),
        .rready       (rready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return {a[15:0], ~a[15:0]};
    endfunction

    // recency list of tags per set, most recent first
    function automatic logic model_access(input addr_t a);
        tag_t   t;
        index_t s;
        int     pos;
        logic   miss;
        t   = a[31:12];
        s   = a[11:5];
        pos = -1;
        for (int k = 0; k < model_cnt[s]; k++)
        begin
            if (model_tags[s][k] == t)
                pos = k;
        end
        miss = (pos < 0);
        if (miss)
        begin
            // full set drops its oldest tag
            if (model_cnt[s] < `ICACHE_WAYS)
                model_cnt[s] = model_cnt[s] + 1;
            pos = model_cnt[s] - 1;
        end
        for (int k = pos; k > 0; k--)
            model_tags[s][k] = model_tags[s][k-1];
        model_tags[s][0] = t;
        return miss;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic wait_accept(output bit done);
        int n;
        done = 1'b0;
        n    = 0;
        while (!done && n < TIMEOUT)
        begin
            @(posedge clk);
            done = inst_addr_ok;
            n++;
        end
    endtask

    task automatic wait_drain(output bit done);
        int n;
        n = 0;
        while (pend_q.size() != 0 && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        done = (pend_q.size() == 0);
    endtask

    // handshakes and CPU responses, sampled at the rising edge
    always @(posedge clk)
    begin
        cycle++;
        ar_fire_q = ar.valid && arready;
        r_fire_q  = r.valid && rready;
        if (!rst)
        begin
            // read data accepted only while a burst is running
            if (mem_phase != 2)
                check_value("rready", rready, 0);
            if (ar_fire_q)
            begin
                ar_addr_q = ar.addr;
                ar_count++;
                if (pend_q.size() == 0)
                begin
                    errors++;
                    $display("AR issued with no request outstanding at %0t", $time);
                end
                else
                begin
                    check_value("ar.addr", ar.addr, {stim_tbl[pend_q[0].idx].addr[31:5], 5'b0});
                    check_value("ar.len", ar.len, LINE_WORDS - 1);
                    check_value("ar.size", ar.size, `AXI_SIZE_WORD);
                    check_value("ar.burst", ar.burst, `AXI_BURST_INCR);
                end
            end
            if (inst_data_ok)
            begin
                if (pend_q.size() == 0)
                begin
                    errors++;
                    $display("inst_data_ok with no request outstanding at %0t", $time);
                end
                else
                begin
                    done_req = pend_q.pop_front();
                    check_value("inst_rdata", inst_rdata,
                                mem_word(stim_tbl[done_req.idx].addr));
                    check_value("ar transfers", ar_count, exp_miss[done_req.idx]);
                    if (!exp_miss[done_req.idx])
                        check_value("data_ok latency", cycle - done_req.acc_cycle, 1);
                    ar_count = 0;
                end
            end
            else if (pend_q.size() != 0 && exp_miss[pend_q[0].idx])
            begin
                check_value("inst_addr_ok", inst_addr_ok, 0);
            end
            if (inst_req && inst_addr_ok)
            begin
                if (cur_idx > 0 && stim_tbl[cur_idx-1].stream && !exp_miss[cur_idx-1])
                    check_value("accept cycle", cycle, last_acc + 1);
                pend_q.push_back('{cur_idx, cycle});
                last_acc = cycle;
            end
        end
    end

    // memory model, 0 idle, 1 address delay, 2 data beats
    always @(negedge clk)
    begin
        if (rst)
        begin
            arready   = 1'b0;
            r         = '0;
            mem_phase = 0;
        end
        else
        begin
            if (ar_fire_q)
            begin
                arready    = 1'b0;
                burst_addr = ar_addr_q;
                beat_idx   = 0;
                mem_cnt    = rand_below(3);
                mem_phase  = 2;
            end
            else if (mem_phase == 0 && ar.valid)
            begin
                mem_cnt   = rand_below(4);
                mem_phase = 1;
            end
            if (mem_phase == 1)
            begin
                if (mem_cnt == 0)
                    arready = 1'b1;
                else
                    mem_cnt--;
            end
            if (mem_phase == 2 && r_fire_q)
            begin
                r.valid  = 1'b0;
                beat_idx = beat_idx + 1;
                mem_cnt  = rand_below(3);
                if (beat_idx == LINE_WORDS)
                    mem_phase = 0;
            end
            if (mem_phase == 2 && !r.valid)
            begin
                if (mem_cnt == 0)
                begin
                    r.data  = mem_word(burst_addr + addr_t'(4 * beat_idx));
                    r.last  = (beat_idx == LINE_WORDS - 1);
                    r.valid = 1'b1;
                end
                else
                begin
                    mem_cnt--;
                end
            end
        end
    end

    initial
    begin
        rst       = 1'b1;
        inst_req  = 1'b0;
        inst_addr = '0;
        cur_idx   = 0;
        aborted   = 1'b0;
        for (int i = 0; i < NUM_STIM; i++)
            exp_miss[i] = model_access(stim_tbl[i].addr);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("ar.valid", ar.valid, 0);
        check_value("inst_data_ok", inst_data_ok, 0);
        check_value("rready", rready, 0);
        rst = 1'b0;

        for (int i = 0; i < NUM_STIM && !aborted; i++)
        begin
            cur_idx   = i;
            inst_req  = 1'b1;
            inst_addr = stim_tbl[i].addr;
            wait_accept(ok);
            @(negedge clk);
            if (!ok)
            begin
                inst_req = 1'b0;
                errors++;
                aborted = 1'b1;
                $display("timeout waiting for inst_addr_ok on request %0d", i);
            end
            else if (!stim_tbl[i].stream)
            begin
                inst_req = 1'b0;
                wait_drain(ok);
                if (!ok)
                begin
                    errors++;
                    aborted = 1'b1;
                    $display("timeout waiting for inst_data_ok on request %0d", i);
                end
            end
        end
        inst_req = 1'b0;
        wait_drain(ok);
        if (!ok)
        begin
            errors++;
            $display("requests still outstanding at the end of the run");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* source/icache_top.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_top
    import icache_pkg::*;
    import axi_rd_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_req,
    input  addr_t   inst_addr,
    output logic    inst_addr_ok,
    output logic    inst_data_ok,
    output word_t   inst_rdata,
    output axi_ar_t ar,
    input  logic    arready,
    input  axi_r_t  r,
    output logic    rready
);

    lookup_t  lookup;
    refill_t  refill;
    way_out_t way_results [`ICACHE_WAYS];
    logic     hit;
    logic     touch;
    way_id_t  victim;

    icache_ctrl i_icache_ctrl (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .lookup       (lookup),
        .refill       (refill),
        .hit          (hit),
        .victim       (victim),
        .touch        (touch),
        .ar           (ar),
        .arready      (arready),
        .r            (r),
        .rready       (rready)
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++)
    begin : g_way
        icache_way #(
            .WAY_ID (w)
        ) i_icache_way (
            .clk    (clk),
            .rst    (rst),
            .lookup (lookup),
            .refill (refill),
            .result (way_results[w])
        );
    end

    icache_hit_lru i_icache_hit_lru (
        .clk     (clk),
        .rst     (rst),
        .index   (lookup.index),
        .results (way_results),
        .touch   (touch),
        .hit     (hit),
        .rdata   (inst_rdata),
        .victim  (victim)
    );

endmodule

/* source/icache_ctrl.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_ctrl
    import icache_pkg::*;
    import axi_rd_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_req,
    input  addr_t   inst_addr,
    output logic    inst_addr_ok,
    output logic    inst_data_ok,
    output lookup_t lookup,
    output refill_t refill,
    input  logic    hit,
    input  way_id_t victim,
    output logic    touch,
    output axi_ar_t ar,
    input  logic    arready,
    input  axi_r_t  r,
    output logic    rready
);

    localparam int OFFSET_W = `ICACHE_ADDR_W - `ICACHE_TAG_W - `ICACHE_INDEX_W;

    ctrl_state_t state;
    ctrl_state_t state_next;
    lookup_t     req_addr;
    way_id_t     victim_way;
    word_sel_t   beat_cnt;
    logic        accept;
    logic        lookup_hit;
    logic        beat;

    assign lookup_hit   = (state == LOOKUP) && hit;
    assign inst_addr_ok = inst_req && ((state == IDLE) || lookup_hit);
    assign accept       = inst_req && inst_addr_ok;
    assign inst_data_ok = lookup_hit;
    assign touch        = lookup_hit;

    assign rready = (state == REFILL);
    assign beat   = r.valid && rready;

    always_comb
    begin
        state_next = state;
        unique case (state)
            IDLE:
            begin
                if (accept)
                    state_next = LOOKUP;
            end
            LOOKUP:
            begin
                if (!hit)
                    state_next = AR_SEND;
                else if (!accept)
                    state_next = IDLE;
            end
            AR_SEND:
            begin
                if (arready)
                    state_next = REFILL;
            end
            REFILL:
            begin
                // line complete, look it up again
                if (beat && r.last)
                    state_next = LOOKUP;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            beat_cnt <= '0;
        else if (state == AR_SEND)
            beat_cnt <= '0;
        else if (beat)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_addr <= inst_addr[`ICACHE_ADDR_W-1:2];
        if ((state == LOOKUP) && !hit)
            victim_way <= victim;
    end

    assign lookup = req_addr;

    // line-aligned incrementing burst
    assign ar.addr  = {req_addr.tag, req_addr.index, {OFFSET_W{1'b0}}};
    assign ar.len   = 8'(`ICACHE_LINE_WORDS - 1);
    assign ar.size  = `AXI_SIZE_WORD;
    assign ar.burst = `AXI_BURST_INCR;
    assign ar.valid = (state == AR_SEND);

    assign refill.wr       = beat;
    assign refill.last     = r.last;
    assign refill.way      = victim_way;
    assign refill.word_sel = beat_cnt;
    assign refill.data     = r.data;
    assign refill.tag      = req_addr.tag;

endmodule

/* source/icache_hit_lru.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_hit_lru
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  index_t   index,
    input  way_out_t results [`ICACHE_WAYS],
    input  logic     touch,
    output logic     hit,
    output word_t    rdata,
    output way_id_t  victim
);

    lru_order_t order_mem [`ICACHE_SETS];
    lru_order_t cur_order;
    lru_order_t next_order;
    way_id_t    hit_way;
    way_id_t    hit_pos;

    // at most one way hits
    always_comb
    begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
            if (results[w].hit)
            begin
                hit     = 1'b1;
                hit_way = way_id_t'(w);
            end
        end
    end

    assign rdata = results[hit_way].data;

    // move to front, entries ahead of the hit slide back one
    always_comb
    begin
        cur_order = order_mem[index];
        hit_pos   = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++)
        begin
            if (cur_order[i] == hit_way)
                hit_pos = way_id_t'(i);
        end
        next_order    = cur_order;
        next_order[0] = hit_way;
        for (int i = 1; i < `ICACHE_WAYS; i++)
        begin
            if (i <= hit_pos)
                next_order[i] = cur_order[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `ICACHE_SETS; s++)
                for (int w = 0; w < `ICACHE_WAYS; w++)
                    order_mem[s][w] <= way_id_t'(w);
        end
        else if (touch)
        begin
            order_mem[index] <= next_order;
        end
    end

    assign victim = cur_order[`ICACHE_WAYS-1];

endmodule

/* icache_way/icache_way.sv */
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_way
    import icache_pkg::*;
#(
    parameter int WAY_ID = 0
)
(
    input  logic     clk,
    input  logic     rst,
    input  lookup_t  lookup,
    input  refill_t  refill,
    output way_out_t result
);

    logic [`ICACHE_SETS-1:0] valid;
    tag_t                    tags [`ICACHE_SETS];
    word_t                   data [`ICACHE_SETS][`ICACHE_LINE_WORDS];
    logic                    wr_en;

    // only the victim way takes the beat
    assign wr_en = refill.wr && (refill.way == way_id_t'(WAY_ID));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid <= '0;
        end
        else if (wr_en && refill.last)
        begin
            valid[lookup.index] <= 1'b1;
        end
    end

    // tag goes in with the final beat
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            data[lookup.index][refill.word_sel] <= refill.data;
            if (refill.last)
            begin
                tags[lookup.index] <= refill.tag;
            end
        end
    end

    assign result.hit  = valid[lookup.index] && (tags[lookup.index] == lookup.tag);
    assign result.data = data[lookup.index][lookup.word_sel];

endmodule

/* common/axi_rd_pkg.sv */
`include "icache_consts.svh"

package axi_rd_pkg;

    // read address channel, master side
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic                      valid;
    } axi_ar_t;

    // read data channel, slave side
    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        valid;
    } axi_r_t;

endpackage

/* common/icache_pkg.sv */
`include "icache_consts.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]          addr_t;
    typedef logic [31:0]                        word_t;
    typedef logic [`ICACHE_TAG_W-1:0]           tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]         index_t;
    typedef logic [`ICACHE_WORD_SEL_W-1:0]      word_sel_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]    way_id_t;

    // entry 0 is most recent, last entry is the victim
    typedef way_id_t [`ICACHE_WAYS-1:0] lru_order_t;

    typedef struct packed {
        tag_t      tag;
        index_t    index;
        word_sel_t word_sel;
    } lookup_t;

    // one refill beat, broadcast to all ways
    typedef struct packed {
        logic      wr;
        logic      last;
        way_id_t   way;
        word_sel_t word_sel;
        word_t     data;
        tag_t      tag;
    } refill_t;

    typedef struct packed {
        logic  hit;
        word_t data;
    } way_out_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        AR_SEND,
        REFILL
    } ctrl_state_t;

endpackage

/* common/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry
`define ICACHE_WAYS        4
`define ICACHE_SETS        128
`define ICACHE_LINE_WORDS  8

// address split, tag | index | word | byte
`define ICACHE_ADDR_W      32
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     7
`define ICACHE_WORD_SEL_W  3

// axi read burst encodings
`define AXI_BURST_INCR     2'b01
`define AXI_SIZE_WORD      3'd2

`endif
